// ==== logic/dviPkg.sv ====
// TMDS link types, DVI control tokens, clock channel pattern
// and serializer ratio

package dviPkg;

    // ------------------------------
    // word types
    // ------------------------------
    typedef logic [9:0]        tmdsWordT;   // one encoded TMDS symbol
    typedef logic [7:0]        colorByteT;  // one colour component
    typedef logic [23:0]       rgbT;        // {red, green, blue}
    typedef logic [1:0]        ctrlT;       // c1:c0 sent in blanking
    typedef logic signed [4:0] disparityT;  // running dc balance count

    // ------------------------------
    // control period tokens
    // ------------------------------
    localparam tmdsWordT CTRL_TOKEN_0 = 10'b1101010100;  // c1:c0 = 00
    localparam tmdsWordT CTRL_TOKEN_1 = 10'b0010101011;  // c1:c0 = 01
    localparam tmdsWordT CTRL_TOKEN_2 = 10'b0101010100;  // c1:c0 = 10
    localparam tmdsWordT CTRL_TOKEN_3 = 10'b1010101011;  // c1:c0 = 11

    // bit 0 goes out first, so the pair shows 1111100000 on the wire
    localparam tmdsWordT CLK_WORD = 10'b00000_11111;

    // ------------------------------
    // link geometry
    // ------------------------------
    localparam int SER_RATIO   = 10;  // tmdsClk cycles per pixel
    localparam int NUM_DATA_CH = 3;   // blue, green, red

endpackage

// ==== logic/timingPkg.sv ====
// video mode geometry for a tiny test raster
// horizontal and vertical ranges, sync polarity

package timingPkg;

    typedef logic [5:0] pixelPosT;  // pixel / line counter

    // ------------------------------
    // horizontal, in pixels
    // ------------------------------
    localparam pixelPosT H_ACTIVE     = 6'd16;
    localparam pixelPosT H_FRONT      = 6'd2;
    localparam pixelPosT H_SYNC       = 6'd4;
    localparam pixelPosT H_BACK       = 6'd2;
    localparam pixelPosT H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 24
    localparam pixelPosT H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam pixelPosT H_SYNC_END   = H_SYNC_START + H_SYNC;  // exclusive

    // ------------------------------
    // vertical, in lines
    // ------------------------------
    localparam pixelPosT V_ACTIVE     = 6'd6;
    localparam pixelPosT V_FRONT      = 6'd1;
    localparam pixelPosT V_SYNC       = 6'd2;
    localparam pixelPosT V_BACK       = 6'd1;
    localparam pixelPosT V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 10
    localparam pixelPosT V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam pixelPosT V_SYNC_END   = V_SYNC_START + V_SYNC;

    localparam logic SYNC_ACTIVE = 1'b1;  // active high syncs

endpackage

// ==== logic/videoIf.sv ====
// video stream between timing generator and TMDS block

interface videoIf;

    logic             pixelStb;  // one cycle, closes each pixel period
    logic             de;        // active video
    logic             hsync;
    logic             vsync;
    dviPkg::rgbT      rgb;       // pixel for the current position

    // timing side, rgb comes from the top level
    modport source (
        output pixelStb,
        output de,
        output hsync,
        output vsync
    );

    // encoder side
    modport sink (
        input pixelStb,
        input de,
        input hsync,
        input vsync,
        input rgb
    );

endinterface

// ==== logic/videoTiming.sv ====
// pixel strobe generator and raster counters
// decodes de, syncs and the requested pixel position

module videoTiming (
    input  logic                tmdsClk,
    input  logic                rstN,
    videoIf.source              vid,
    output timingPkg::pixelPosT pixelX,
    output timingPkg::pixelPosT pixelY
);

    logic [3:0]          phase;     // position inside one pixel period
    logic                stb;
    timingPkg::pixelPosT hCount;
    timingPkg::pixelPosT vCount;
    logic                hActive;
    logic                vActive;
    logic                hSyncOn;
    logic                vSyncOn;

    // ------------------------------
    // pixel phase and strobe
    // ------------------------------
    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
            stb   <= 1'b0;
        end else begin
            if (phase == 4'(dviPkg::SER_RATIO - 1)) begin
                phase <= '0;                    // wrap after phase 9
            end else begin
                phase <= phase + 4'd1;
            end
            stb <= (phase == 4'(dviPkg::SER_RATIO - 2));  // high during phase 9
        end
    end

    // ------------------------------
    // raster counters
    // ------------------------------
    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (stb) begin               // advance once per pixel
            if (hCount == timingPkg::H_TOTAL - 6'd1) begin
                hCount <= '0;
                if (vCount == timingPkg::V_TOTAL - 6'd1) begin
                    vCount <= '0;             // new frame
                end else begin
                    vCount <= vCount + 6'd1;
                end
            end else begin
                hCount <= hCount + 6'd1;
            end
        end
    end

    // decodes follow the counters, so all change at the strobe edge
    assign hActive = (hCount < timingPkg::H_ACTIVE);
    assign vActive = (vCount < timingPkg::V_ACTIVE);
    assign hSyncOn = (hCount >= timingPkg::H_SYNC_START) && (hCount < timingPkg::H_SYNC_END);
    assign vSyncOn = (vCount >= timingPkg::V_SYNC_START) && (vCount < timingPkg::V_SYNC_END);

    assign vid.pixelStb = stb;
    assign vid.de       = hActive && vActive;
    assign vid.hsync    = hSyncOn ? timingPkg::SYNC_ACTIVE : ~timingPkg::SYNC_ACTIVE;
    assign vid.vsync    = vSyncOn ? timingPkg::SYNC_ACTIVE : ~timingPkg::SYNC_ACTIVE;

    assign pixelX = (hActive && vActive) ? hCount : '0;  // zero in blanking
    assign pixelY = (hActive && vActive) ? vCount : '0;

    // ------------------------------
    // checks
    // ------------------------------
    deNoSync: assert property (@(posedge tmdsClk) disable iff (!rstN)
        vid.de |-> (vid.hsync != timingPkg::SYNC_ACTIVE) &&
                   (vid.vsync != timingPkg::SYNC_ACTIVE))
        else $error("de overlaps a sync pulse");

    stbPeriod: assert property (@(posedge tmdsClk) disable iff (!rstN)
        stb |=> (!stb) [* dviPkg::SER_RATIO - 1] ##1 stb)
        else $error("pixel strobe not one cycle in ten");

endmodule

// ==== logic/tmdsEncoder.sv ====
// DVI TMDS channel encoder, 8b10b with running disparity
// and control tokens during blanking

module tmdsEncoder (
    input  logic              tmdsClk,
    input  logic              rstN,
    input  logic              pixelStb,
    input  logic              de,
    input  dviPkg::colorByteT data,
    input  dviPkg::ctrlT      ctrl,
    output dviPkg::tmdsWordT  word
);

    logic [3:0]        onesData;    // ones in the input byte
    logic [3:0]        onesQm;      // ones in the minimized byte
    logic              useXnor;
    logic [8:0]        qm;          // transition minimized, bit 8 = xor used
    dviPkg::disparityT disparity;
    dviPkg::disparityT qmBal;       // ones minus zeros of qm[7:0]
    dviPkg::disparityT dispNext;
    dviPkg::tmdsWordT  dataWord;
    dviPkg::tmdsWordT  ctrlWord;

    function automatic logic [3:0] countOnes(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, v[i]};
        end
        return n;
    endfunction

    // ------------------------------
    // stage 1, minimize transitions
    // ------------------------------
    assign onesData = countOnes(data);
    assign useXnor  = (onesData > 4'd4) || ((onesData == 4'd4) && !data[0]);

    always_comb begin
        qm[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = qm[i-1] ^ data[i] ^ useXnor;  // xnor is xor with 1
        end
        qm[8] = ~useXnor;
    end

    assign onesQm = countOnes(qm[7:0]);
    assign qmBal  = dviPkg::disparityT'({onesQm, 1'b0} - 5'd8);  // 2*ones - 8

    // ------------------------------
    // stage 2, dc balance
    // ------------------------------
    always_comb begin
        if ((disparity == 0) || (qmBal == 0)) begin
            dataWord = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            dispNext = qm[8] ? disparity + qmBal : disparity - qmBal;
        end else if (((disparity > 0) && (qmBal > 0)) ||
                     ((disparity < 0) && (qmBal < 0))) begin
            dataWord = {1'b1, qm[8], ~qm[7:0]};  // invert to pull back
            dispNext = disparity - qmBal + (qm[8] ? 5'sd2 : 5'sd0);
        end else begin
            dataWord = {1'b0, qm[8], qm[7:0]};
            dispNext = disparity + qmBal - (qm[8] ? 5'sd0 : 5'sd2);
        end
    end

    always_comb begin
        unique case (ctrl)
            2'b00:   ctrlWord = dviPkg::CTRL_TOKEN_0;
            2'b01:   ctrlWord = dviPkg::CTRL_TOKEN_1;
            2'b10:   ctrlWord = dviPkg::CTRL_TOKEN_2;
            default: ctrlWord = dviPkg::CTRL_TOKEN_3;
        endcase
    end

    // one word per pixel period
    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            word      <= dviPkg::CTRL_TOKEN_0;
            disparity <= '0;
        end else if (pixelStb) begin
            if (de) begin
                word      <= dataWord;
                disparity <= dispNext;
            end else begin
                word      <= ctrlWord;
                disparity <= '0;              // blanking restarts the balance
            end
        end
    end

    dispBound: assert property (@(posedge tmdsClk) disable iff (!rstN)
        (disparity >= -5'sd10) && (disparity <= 5'sd10))
        else $error("running disparity out of range: %0d", disparity);

endmodule

// ==== logic/tmdsSerializer.sv ====
// 10 to 1 TMDS serializer shifting LSB first
// drives one complementary output pair

module tmdsSerializer (
    input  logic             tmdsClk,
    input  logic             rstN,
    input  logic             pixelStb,
    input  dviPkg::tmdsWordT word,
    output logic             pos,
    output logic             neg
);

    logic [8:0] shiftReg;  // bits still to go, next one at bit 0
    logic       nextBit;

    // on load the first bit bypasses the shift register
    assign nextBit = pixelStb ? word[0] : shiftReg[0];

    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= '0;
        end else if (pixelStb) begin
            shiftReg <= word[9:1];              // bit 0 leaves right away
        end else begin
            shiftReg <= {1'b0, shiftReg[8:1]};  // shift right
        end
    end

    // ------------------------------
    // registered output pair
    // ------------------------------
    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            pos <= 1'b0;
            neg <= 1'b1;
        end else begin
            pos <= nextBit;
            neg <= ~nextBit;
        end
    end

    // all nine held bits gone before the next word comes in
    loadAfterDrain: assert property (@(posedge tmdsClk) disable iff (!rstN)
        pixelStb |-> (shiftReg == '0))
        else $error("word loaded before the previous one was sent");

endmodule

// ==== logic/tgbWrapper.sv ====
// TMDS generate block: three channel encoders, three data serializers
// and the clock channel serializer

module tgbWrapper (
    input  logic                             tmdsClk,
    input  logic                             rstN,
    videoIf.sink                             vid,
    output logic [dviPkg::NUM_DATA_CH-1:0]   hdmiDataPos,
    output logic [dviPkg::NUM_DATA_CH-1:0]   hdmiDataNeg,
    output logic                             hdmiClkPos,
    output logic                             hdmiClkNeg
);

    dviPkg::colorByteT chData [dviPkg::NUM_DATA_CH];  // byte per channel
    dviPkg::ctrlT      chCtrl [dviPkg::NUM_DATA_CH];  // control bits per channel
    dviPkg::tmdsWordT  chWord [dviPkg::NUM_DATA_CH];  // encoded symbols

    // ------------------------------
    // channel mapping
    // ------------------------------
    assign chData[0] = vid.rgb[7:0];          // ch0 blue
    assign chData[1] = vid.rgb[15:8];         // ch1 green
    assign chData[2] = vid.rgb[23:16];        // ch2 red
    assign chCtrl[0] = {vid.vsync, vid.hsync};  // syncs ride on blue
    assign chCtrl[1] = 2'b00;
    assign chCtrl[2] = 2'b00;

    // ------------------------------
    // encode and serialize
    // ------------------------------
    for (genvar ch = 0; ch < dviPkg::NUM_DATA_CH; ch++) begin : channel
        tmdsEncoder encoder (
            .tmdsClk  (tmdsClk),
            .rstN     (rstN),
            .pixelStb (vid.pixelStb),
            .de       (vid.de),
            .data     (chData[ch]),
            .ctrl     (chCtrl[ch]),
            .word     (chWord[ch])
        );

        tmdsSerializer serializer (
            .tmdsClk  (tmdsClk),
            .rstN     (rstN),
            .pixelStb (vid.pixelStb),
            .word     (chWord[ch]),
            .pos      (hdmiDataPos[ch]),
            .neg      (hdmiDataNeg[ch])
        );
    end

    // clock pair, one fixed pattern per pixel, aligned to the data symbols
    tmdsSerializer clkSerializer (
        .tmdsClk  (tmdsClk),
        .rstN     (rstN),
        .pixelStb (vid.pixelStb),
        .word     (dviPkg::CLK_WORD),
        .pos      (hdmiClkPos),
        .neg      (hdmiClkNeg)
    );

endmodule

// ==== logic/dviTop.sv ====
// DVI transmitter top: timing generator, video stream, TMDS block

module dviTop (
    input  logic                           tmdsClk,
    input  logic                           rstN,
    input  dviPkg::rgbT                    rgb,          // pixel for pixelX/pixelY
    output timingPkg::pixelPosT            pixelX,
    output timingPkg::pixelPosT            pixelY,
    output logic                           pixelStb,     // ends each pixel period
    output logic [dviPkg::NUM_DATA_CH-1:0] hdmiDataPos,
    output logic [dviPkg::NUM_DATA_CH-1:0] hdmiDataNeg,
    output logic                           hdmiClkPos,
    output logic                           hdmiClkNeg
);

    videoIf vid ();

    assign vid.rgb  = rgb;            // external source, no handshake
    assign pixelStb = vid.pixelStb;

    // ------------------------------
    // raster and strobe
    // ------------------------------
    videoTiming timingGen (
        .tmdsClk (tmdsClk),
        .rstN    (rstN),
        .vid     (vid.source),
        .pixelX  (pixelX),
        .pixelY  (pixelY)
    );

    // ------------------------------
    // encode and drive the link
    // ------------------------------
    tgbWrapper tgb (
        .tmdsClk     (tmdsClk),
        .rstN        (rstN),
        .vid         (vid.sink),
        .hdmiDataPos (hdmiDataPos),
        .hdmiDataNeg (hdmiDataNeg),
        .hdmiClkPos  (hdmiClkPos),
        .hdmiClkNeg  (hdmiClkNeg)
    );

endmodule

// ==== test/dviTb.sv ====
// testbench for the DVI transmitter: random pixel source, timing and TMDS model,
// serial capture of all four pairs, compare tasks and watchdog

module dviTb;

    localparam int RUN_PIXELS      = 3 * timingPkg::H_TOTAL * timingPkg::V_TOTAL;  // 3 frames
    localparam int WATCHDOG_CYCLES = RUN_PIXELS * dviPkg::SER_RATIO + 800;

    logic                tmdsClk;
    logic                rstN;
    dviPkg::rgbT         rgb;
    timingPkg::pixelPosT pixelX;
    timingPkg::pixelPosT pixelY;
    logic                pixelStb;
    logic [2:0]          hdmiDataPos;
    logic [2:0]          hdmiDataNeg;
    logic                hdmiClkPos;
    logic                hdmiClkNeg;

    integer              seed;
    logic [31:0]         randWord;
    timingPkg::pixelPosT hModel;           // model raster position
    timingPkg::pixelPosT vModel;
    int                  dispModel [3];    // model disparity per channel
    logic [29:0]         expWordQ [$];     // {red, green, blue} words
    dviPkg::rgbT         rgbQ [$];
    logic [2:0]          videoQ [$];       // {de, vsync, hsync}
    dviPkg::tmdsWordT    rxWord [3];       // deserialized data channels
    dviPkg::tmdsWordT    rxClk;
    int                  bitIdx;
    logic                inSym;
    logic                clkPrev;
    int                  symCount;         // symbols checked, fill included
    int                  stbGap;
    logic                stbSeen;

    dviTop uut (
        .tmdsClk     (tmdsClk),
        .rstN        (rstN),
        .rgb         (rgb),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .pixelStb    (pixelStb),
        .hdmiDataPos (hdmiDataPos),
        .hdmiDataNeg (hdmiDataNeg),
        .hdmiClkPos  (hdmiClkPos),
        .hdmiClkNeg  (hdmiClkNeg)
    );

    always #5 tmdsClk = ~tmdsClk;

    // ------------------------------
    // reporting and compares
    // ------------------------------
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input dviPkg::tmdsWordT got, input dviPkg::tmdsWordT exp,
                             input string what);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch at time %0t: %s got %b expected %b",
                                  $time, what, got, exp));
        end
    endtask

    task automatic checkPixel(input dviPkg::rgbT got, input dviPkg::rgbT exp, input string what);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch at time %0t: %s got %h expected %h",
                                  $time, what, got, exp));
        end
    endtask

    task automatic checkPosition(input timingPkg::pixelPosT got,
                                 input timingPkg::pixelPosT exp, input string what);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch at time %0t: %s got %0d expected %0d",
                                  $time, what, got, exp));
        end
    endtask

    // ------------------------------
    // reference TMDS model
    // ------------------------------
    function automatic int onesIn(input logic [7:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (v[i]) n++;
        end
        return n;
    endfunction

    function automatic dviPkg::tmdsWordT tokenFor(input dviPkg::ctrlT c);
        case (c)
            2'b00:   return dviPkg::CTRL_TOKEN_0;
            2'b01:   return dviPkg::CTRL_TOKEN_1;
            2'b10:   return dviPkg::CTRL_TOKEN_2;
            default: return dviPkg::CTRL_TOKEN_3;
        endcase
    endfunction

    // DVI 1.0 encode flow, counts kept as plain ints
    function automatic dviPkg::tmdsWordT modelEncode(input logic de, input dviPkg::ctrlT c,
            input dviPkg::colorByteT d, input int cntIn, output int cntOut);
        logic       xnorSel;
        logic [8:0] qm;
        int         n1;
        int         n0;
        if (!de) begin
            cntOut = 0;                                 // blanking clears the count
            return tokenFor(c);
        end
        xnorSel = (onesIn(d) > 4) || ((onesIn(d) == 4) && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = xnorSel ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xnorSel;
        n1 = onesIn(qm[7:0]);
        n0 = 8 - n1;
        if ((cntIn == 0) || (n1 == n0)) begin
            cntOut = qm[8] ? cntIn + n1 - n0 : cntIn + n0 - n1;
            return {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        end else if (((cntIn > 0) && (n1 > n0)) || ((cntIn < 0) && (n0 > n1))) begin
            cntOut = cntIn + (qm[8] ? 2 : 0) + n0 - n1;
            return {1'b1, qm[8], ~qm[7:0]};            // inverted byte
        end
        cntOut = cntIn - (qm[8] ? 0 : 2) + n1 - n0;
        return {1'b0, qm[8], qm[7:0]};
    endfunction

    // inverse TMDS, word back to colour byte
    function automatic dviPkg::colorByteT decodeWord(input dviPkg::tmdsWordT w);
        logic [7:0]        q;
        dviPkg::colorByteT b;
        q = w[9] ? ~w[7:0] : w[7:0];
        b[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = w[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return b;
    endfunction

    // called at the negedge before a strobe edge, inputs as the encoders see them
    task automatic samplePixel();
        logic             de;
        logic             hs;
        logic             vs;
        dviPkg::tmdsWordT w [3];
        int               nextDisp;
        de = (hModel < timingPkg::H_ACTIVE) && (vModel < timingPkg::V_ACTIVE);
        hs = ((hModel >= timingPkg::H_ACTIVE + timingPkg::H_FRONT) &&
              (hModel < timingPkg::H_ACTIVE + timingPkg::H_FRONT + timingPkg::H_SYNC)) ?
             timingPkg::SYNC_ACTIVE : ~timingPkg::SYNC_ACTIVE;
        vs = ((vModel >= timingPkg::V_ACTIVE + timingPkg::V_FRONT) &&
              (vModel < timingPkg::V_ACTIVE + timingPkg::V_FRONT + timingPkg::V_SYNC)) ?
             timingPkg::SYNC_ACTIVE : ~timingPkg::SYNC_ACTIVE;
        checkPosition(pixelX, de ? hModel : timingPkg::pixelPosT'(0), "pixelX");
        checkPosition(pixelY, de ? vModel : timingPkg::pixelPosT'(0), "pixelY");
        for (int ch = 0; ch < 3; ch++) begin
            w[ch] = modelEncode(de, (ch == 0) ? {vs, hs} : 2'b00, rgb[8*ch +: 8],
                                dispModel[ch], nextDisp);
            dispModel[ch] = nextDisp;
        end
        expWordQ.push_back({w[2], w[1], w[0]});
        rgbQ.push_back(rgb);
        videoQ.push_back({de, vs, hs});
        if (hModel == timingPkg::H_TOTAL - 6'd1) begin      // next line
            hModel = '0;
            vModel = (vModel == timingPkg::V_TOTAL - 6'd1) ? '0 : vModel + 6'd1;
        end else begin
            hModel = hModel + 6'd1;
        end
    endtask

    task automatic checkSymbol();
        logic [29:0] exp;
        dviPkg::rgbT pix;
        logic [2:0]  vid;
        checkWord(rxClk, 10'b00000_11111, "clock pair");   // five ones first on the wire
        if (symCount == 0) begin
            // encoder reset word, out before the first pixel arrives
            for (int ch = 0; ch < 3; ch++) begin
                checkWord(rxWord[ch], dviPkg::CTRL_TOKEN_0, "fill symbol");
            end
        end else begin
            if (expWordQ.size() == 0) begin
                stopOnError("symbol captured with no pixel in the model queue");
            end
            exp = expWordQ.pop_front();
            pix = rgbQ.pop_front();
            vid = videoQ.pop_front();
            for (int ch = 0; ch < 3; ch++) begin
                checkWord(rxWord[ch], exp[10*ch +: 10], $sformatf("channel %0d word", ch));
            end
            if (vid[2]) begin
                checkPixel({decodeWord(rxWord[2]), decodeWord(rxWord[1]),
                            decodeWord(rxWord[0])}, pix, "decoded pixel");
            end else begin
                checkWord(rxWord[0], tokenFor(vid[1:0]), "channel 0 sync token");
                checkWord(rxWord[1], dviPkg::CTRL_TOKEN_0, "channel 1 token");
                checkWord(rxWord[2], dviPkg::CTRL_TOKEN_0, "channel 2 token");
            end
        end
        symCount++;
    endtask

    // ------------------------------
    // stimulus, capture, watchdog
    // ------------------------------
    initial begin
        seed      = 32'h2ac2b115;
        tmdsClk   = 1'b0;
        rstN      = 1'b0;
        randWord  = $random(seed);
        rgb       = randWord[23:0];
        hModel    = '0;
        vModel    = '0;
        dispModel = '{0, 0, 0};
        bitIdx    = 0;
        inSym     = 1'b0;
        clkPrev   = 1'b0;
        symCount  = 0;
        stbGap    = 0;
        stbSeen   = 1'b0;
        repeat (8) @(posedge tmdsClk);
        #1;
        rstN = 1'b1;
        wait (symCount > RUN_PIXELS);                      // fill plus three frames
        $display("test passed");
        $finish;
    end

    always @(negedge tmdsClk) begin
        if (rstN && pixelStb) begin
            samplePixel();
            @(posedge tmdsClk);
            #1;
            randWord = $random(seed);                      // next pixel after the strobe
            rgb      = randWord[23:0];
        end
    end

    always @(negedge tmdsClk) begin
        if (rstN) begin
            if ((hdmiDataNeg !== ~hdmiDataPos) || (hdmiClkNeg !== ~hdmiClkPos)) begin
                stopOnError("an output pair is not complementary");
            end
            stbGap++;
            if (pixelStb) begin
                if (stbSeen && (stbGap != dviPkg::SER_RATIO)) begin
                    stopOnError($sformatf("mismatch at time %0t: pixelStb gap %0d expected %0d",
                                          $time, stbGap, dviPkg::SER_RATIO));
                end
                stbSeen = 1'b1;
                stbGap  = 0;
            end
            if (hdmiClkPos && !clkPrev) begin              // symbol start
                if (inSym && (bitIdx != 9)) begin
                    stopOnError("clock pair started a symbol before ten bits");
                end
                inSym  = 1'b1;
                bitIdx = 0;
            end else if (inSym) begin
                bitIdx++;
            end
            clkPrev = hdmiClkPos;
            if (inSym) begin
                if (bitIdx > 9) begin
                    stopOnError("clock pair missed a symbol start");
                end
                rxClk[bitIdx] = hdmiClkPos;
                for (int ch = 0; ch < 3; ch++) begin
                    rxWord[ch][bitIdx] = hdmiDataPos[ch];  // LSB arrives first
                end
                if (bitIdx == 9) checkSymbol();
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge tmdsClk);
        stopOnError("watchdog expired, the run did not finish");
    end

endmodule

// ==== filelist.f ====
logic/dviPkg.sv
logic/timingPkg.sv
logic/videoIf.sv
logic/videoTiming.sv
logic/tmdsEncoder.sv
logic/tmdsSerializer.sv
logic/tgbWrapper.sv
logic/dviTop.sv
test/dviTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := dviTb
FILELIST   := filelist.f
OBJDIR     := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
